//--- trellisTop.f
+incdir+source
source/trellisTopPkg.sv
source/hostBus.sv
source/miscControl.sv
source/dacChannel.sv
source/trellisTop.sv
verification/trellisTop_checker.sv
verification/trellisTopTb.sv

//--- verification/trellisTopTb.sv
// Testbench for trellisTop, a bus access spans one edge
// Read data is sampled 1 ns after the access edge, inputs change 2 ns after it

`include "trellisTop_cfg.svh"

module trellisTopTb
  import trellisTopPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic                             ck933 = 1'b0;
  logic                             clockCounterEn;
  logic                             nCs;
  logic                             nWe;
  logic                             nRd;
  logic [`TRELLIS_ADDR_WIDTH-1:0]   addr;
  logic [`TRELLIS_DATA_WIDTH-1:0]   wrData;
  logic [`TRELLIS_DATA_WIDTH-1:0]   rdData;
  logic [`TRELLIS_SAMPLE_WIDTH-1:0] demodSample [`TRELLIS_DAC_CHANNELS];
  logic                             demodSync [`TRELLIS_DAC_CHANNELS];
  logic [`TRELLIS_SAMPLE_WIDTH-1:0] trellisSample [`TRELLIS_DAC_CHANNELS];
  logic                             trellisSync [`TRELLIS_DAC_CHANNELS];
  logic [`TRELLIS_DAC_WIDTH-1:0]    dacData [`TRELLIS_DAC_CHANNELS];
  logic                             dacRst;
  integer                           seed = 32'hc313;
  int                               edgeCount = 0;
  int                               errors = 0;
  int                               testBase = 0;
  int                               passCount = 0;
  int                               failCount = 0;

  always #20 ck933 = ~ck933;

  always @(posedge ck933) begin
    edgeCount++;
  end

  trellisTop i_trellisTop (
    .ck933           (ck933),
    .clockCounterEn  (clockCounterEn),
    .nCs_i           (nCs),
    .nWe_i           (nWe),
    .nRd_i           (nRd),
    .addr_i          (addr),
    .wrData_i        (wrData),
    .demodSample_i   (demodSample),
    .demodSync_i     (demodSync),
    .trellisSample_i (trellisSample),
    .trellisSync_i   (trellisSync),
    .rdData_o        (rdData),
    .dacData_o       (dacData),
    .dacRst_o        (dacRst)
  );

  // **************************************************
  // Reporting
  // **************************************************

  function automatic int failTotal();
    return errors + i_trellisTop.i_trellisTopChecker.assertFails;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s expected %0h got %0h", $time, what, exp, got);
    end
  endtask

  task automatic finishTest(input string name);
    if (failTotal() == testBase) begin
      passCount++;
      $display("Test %s passed", name);
    end else begin
      failCount++;
      $display("Test %s failed", name);
    end
    testBase = failTotal();
  endtask

  // **************************************************
  // Bus and sample drivers
  // **************************************************

  task automatic busWrite(input logic [11:0] a, input logic [15:0] d, output int wEdge);
    @(posedge ck933);
    #2;
    nCs = 1'b0;
    nWe = 1'b0;
    addr = a;
    wrData = d;
    @(posedge ck933);
    #1;
    wEdge = edgeCount;
    #1;
    nCs = 1'b1;
    nWe = 1'b1;
  endtask

  task automatic busRead(input logic [11:0] a, output logic [15:0] d, output int rEdge);
    @(posedge ck933);
    #2;
    nCs = 1'b0;
    nRd = 1'b0;
    addr = a;
    @(posedge ck933);
    #1;
    rEdge = edgeCount;
    d = rdData;
    #1;
    nCs = 1'b1;
    nRd = 1'b1;
  endtask

  // Counts cycles with dacRst_o high, samples 1 ns after each edge
  task automatic waitResetLow(input int limit, output int highCycles);
    highCycles = 0;
    while (dacRst) begin
      if (highCycles >= limit) begin
        $display("Timeout: dacRst_o still high after %0d cycles", limit);
        $display("Simulation failed");
        $finish;
      end
      @(posedge ck933);
      #1;
      highCycles++;
    end
  endtask

  // Both streams get different random samples, held for one edge
  task automatic driveSamples(input int ch, input logic sync,
                              output logic [17:0] dS, output logic [17:0] tS);
    @(posedge ck933);
    #2;
    dS = $random(seed);
    tS = $random(seed);
    if (dS[17:4] == tS[17:4]) begin
      tS[4] = ~tS[4];
    end
    demodSample[ch] = dS;
    trellisSample[ch] = tS;
    demodSync[ch] = sync;
    trellisSync[ch] = sync;
    @(posedge ck933);
    #2;
    demodSync[ch] = 1'b0;
    trellisSync[ch] = 1'b0;
  endtask

  // **************************************************
  // Test sequence
  // **************************************************

  initial begin : main
    int          wEdge;
    int          rEdge;
    int          waitEdges;
    int          highCycles;
    logic [15:0] hi;
    logic [15:0] lo;
    logic [17:0] dS;
    logic [17:0] tS;
    logic [17:0] pick;
    logic [13:0] lastWord [`TRELLIS_DAC_CHANNELS];
    dacSource_t  codeList [3];

    codeList[0] = srcDemod;
    codeList[1] = srcTrellisI;
    codeList[2] = srcTrellisIndex;
    clockCounterEn = 1'b1;
    nCs = 1'b1;
    nWe = 1'b1;
    nRd = 1'b1;
    addr = '0;
    wrData = '0;
    for (int ch = 0; ch < `TRELLIS_DAC_CHANNELS; ch++) begin
      demodSample[ch] = '0;
      demodSync[ch] = 1'b0;
      trellisSample[ch] = '0;
      trellisSync[ch] = 1'b0;
      lastWord[ch] = '0;
    end
    repeat (16) @(posedge ck933);
    #2;
    clockCounterEn = 1'b0;

    waitResetLow(4, highCycles);
    for (int ch = 0; ch < `TRELLIS_DAC_CHANNELS; ch++) begin
      checkValue("dacData after reset", dacData[ch], 0);
      busRead(12'h100 + 12'(ch * 4), lo, rEdge);
      checkValue("DAC source after reset", lo, srcDemod);
    end
    finishTest("reset state");

    busRead(12'h006, hi, rEdge);
    checkValue("version high half", hi, `TRELLIS_VERSION);
    busRead(12'h004, lo, rEdge);
    checkValue("version low half", lo, 0);
    busRead(12'h200, lo, rEdge);
    checkValue("unmapped space", lo, 0);
    busRead(12'h00c, lo, rEdge);
    checkValue("unmapped misc register", lo, 0);
    finishTest("version and unmapped reads");

    // Capture of the low-half read sets the expected count
    repeat (3) begin
      busWrite(12'h008, 16'($random(seed)), wEdge);
      waitEdges = 1 + ($unsigned($random(seed)) % 20);
      for (int n = 0; n < waitEdges; n++) begin
        @(posedge ck933);
      end
      busRead(12'h00a, hi, rEdge);
      busRead(12'h008, lo, rEdge);
      checkValue("clock capture", {hi, lo}, rEdge - wEdge - 1);
    end
    finishTest("clock counter");

    for (int ch = 0; ch < `TRELLIS_DAC_CHANNELS; ch++) begin
      busWrite(12'h100 + 12'(ch * 4), 16'(ch + 1), wEdge);
      busRead(12'h100 + 12'(ch * 4), lo, rEdge);
      checkValue("DAC source readback", lo, ch + 1);
    end
    busRead(12'h000, lo, rEdge);
    waitResetLow(20, highCycles);
    checkValue("soft reset length", highCycles, `TRELLIS_RESET_CYCLES);
    for (int ch = 0; ch < `TRELLIS_DAC_CHANNELS; ch++) begin
      busRead(12'h100 + 12'(ch * 4), lo, rEdge);
      checkValue("DAC source after soft reset", lo, srcDemod);
    end
    finishTest("soft reset");

    for (int ch = 0; ch < `TRELLIS_DAC_CHANNELS; ch++) begin
      for (int k = 0; k < 3; k++) begin
        busWrite(12'h100 + 12'(ch * 4), {12'h000, codeList[k]}, wEdge);
        driveSamples(ch, 1'b1, dS, tS);
        @(posedge ck933);
        #1;
        pick = (codeList[k] == srcDemod) ? dS : tS;
        lastWord[ch] = {~pick[17], pick[16:4]};
        checkValue("DAC word", dacData[ch], lastWord[ch]);
      end
    end
    finishTest("DAC sample path");

    // The last word loaded per channel must survive a sample without sync
    for (int ch = 0; ch < `TRELLIS_DAC_CHANNELS; ch++) begin
      driveSamples(ch, 1'b0, dS, tS);
      @(posedge ck933);
      #1;
      checkValue("DAC word with sync low", dacData[ch], lastWord[ch]);
    end
    finishTest("sync low hold");

    $display("Tests passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0 && failTotal() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verification/trellisTop_checker.sv
// Concurrent assertions bound into trellisTop
// Soft reset, idle read data and DAC pipeline rules, failures are counted in assertFails

`include "trellisTop_cfg.svh"

module trellisTop_checker
  import trellisTopPkg::*;
(
  input logic                             ck933,
  input logic                             clockCounterEn,
  input logic                             nCs_i,
  input logic                             nRd_i,
  input logic [`TRELLIS_ADDR_WIDTH-1:0]   addr_i,
  input logic [`TRELLIS_DATA_WIDTH-1:0]   rdData_i,
  input logic                             dacRst_i,
  input dacSource_t                       dacSource_i [`TRELLIS_DAC_CHANNELS],
  input logic [`TRELLIS_SAMPLE_WIDTH-1:0] demodSample_i [`TRELLIS_DAC_CHANNELS],
  input logic                             demodSync_i [`TRELLIS_DAC_CHANNELS],
  input logic [`TRELLIS_SAMPLE_WIDTH-1:0] trellisSample_i [`TRELLIS_DAC_CHANNELS],
  input logic                             trellisSync_i [`TRELLIS_DAC_CHANNELS],
  input logic [`TRELLIS_DAC_WIDTH-1:0]    dacData_i [`TRELLIS_DAC_CHANNELS]
);

  timeunit 1ns;
  timeprecision 100ps;

  int                               assertFails = 0;
  logic                             resetRead;
  logic [`TRELLIS_SAMPLE_WIDTH-1:0] chkSample [`TRELLIS_DAC_CHANNELS];
  logic                             chkSync [`TRELLIS_DAC_CHANNELS];

  // Codes 1 to 4 pick the trellis stream
  function automatic logic isTrellis(input logic [3:0] code);
    return (code >= 4'd1) && (code <= 4'd4);
  endfunction

  // Top sample bits with the sign flipped
  function automatic logic [`TRELLIS_DAC_WIDTH-1:0] offsetWord(
    input logic [`TRELLIS_SAMPLE_WIDTH-1:0] s);
    return {~s[17], s[16:4]};
  endfunction

  // **************************************************
  // Registered select, one stage ahead of the output
  // **************************************************

  always_ff @(posedge ck933 or posedge dacRst_i) begin
    if (dacRst_i) begin
      for (int i = 0; i < `TRELLIS_DAC_CHANNELS; i++) begin
        chkSync[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < `TRELLIS_DAC_CHANNELS; i++) begin
        chkSync[i] <= isTrellis(dacSource_i[i]) ? trellisSync_i[i] : demodSync_i[i];
      end
    end
  end

  always_ff @(posedge ck933) begin
    for (int i = 0; i < `TRELLIS_DAC_CHANNELS; i++) begin
      chkSample[i] <= isTrellis(dacSource_i[i]) ? trellisSample_i[i] : demodSample_i[i];
    end
  end

  // **************************************************
  // Reset and bus rules
  // **************************************************

  assign resetRead = !nCs_i && !nRd_i && (addr_i[11:2] == 10'd0);

  // Pulse of exactly six cycles, starting the cycle after the access edge
  assert property (@(posedge ck933) disable iff (clockCounterEn)
    ($fell(nCs_i) && resetRead) |=> dacRst_i [*6] ##1 !dacRst_i)
  else begin
    assertFails++;
    $error("soft reset pulse has the wrong length");
  end

  assert property (@(posedge ck933) $fell(dacRst_i) |->
    (dacData_i[0] == '0) && (dacData_i[1] == '0) && (dacData_i[2] == '0) &&
    (dacSource_i[0] == srcDemod) && (dacSource_i[1] == srcDemod) &&
    (dacSource_i[2] == srcDemod))
  else begin
    assertFails++;
    $error("DAC state is not cleared when reset ends");
  end

  assert property (@(posedge ck933) disable iff (clockCounterEn)
    (nCs_i || nRd_i) |-> (rdData_i == '0))
  else begin
    assertFails++;
    $error("read data is not zero outside a read access");
  end

  // **************************************************
  // DAC output per channel
  // **************************************************

  for (genvar i = 0; i < `TRELLIS_DAC_CHANNELS; i++) begin : gChan
    assert property (@(posedge ck933) disable iff (dacRst_i)
      chkSync[i] |=> (dacData_i[i] == offsetWord($past(chkSample[i]))))
    else begin
      assertFails++;
      $error("DAC channel %0d loaded a wrong word", i);
    end

    assert property (@(posedge ck933) disable iff (dacRst_i)
      !chkSync[i] |=> $stable(dacData_i[i]))
    else begin
      assertFails++;
      $error("DAC channel %0d changed without sync", i);
    end
  end

endmodule

bind trellisTop trellisTop_checker i_trellisTopChecker (
  .ck933           (ck933),
  .clockCounterEn  (clockCounterEn),
  .nCs_i           (nCs_i),
  .nRd_i           (nRd_i),
  .addr_i          (addr_i),
  .rdData_i        (rdData_o),
  .dacRst_i        (dacRst_o),
  .dacSource_i     (dacSource),
  .demodSample_i   (demodSample_i),
  .demodSync_i     (demodSync_i),
  .trellisSample_i (trellisSample_i),
  .trellisSync_i   (trellisSync_i),
  .dacData_i       (dacData_o)
);

//--- source/trellisTop.sv
// Host control and DAC output side of the trellis demodulator
// Sample streams arrive strobe-qualified and cannot be stalled

`include "trellisTop_cfg.svh"

module trellisTop
  import trellisTopPkg::*;
(
  input  logic                             ck933,
  input  logic                             clockCounterEn,
  input  logic                             nCs_i,
  input  logic                             nWe_i,
  input  logic                             nRd_i,
  input  logic [`TRELLIS_ADDR_WIDTH-1:0]   addr_i,
  input  logic [`TRELLIS_DATA_WIDTH-1:0]   wrData_i,
  input  logic [`TRELLIS_SAMPLE_WIDTH-1:0] demodSample_i [`TRELLIS_DAC_CHANNELS],
  input  logic                             demodSync_i [`TRELLIS_DAC_CHANNELS],
  input  logic [`TRELLIS_SAMPLE_WIDTH-1:0] trellisSample_i [`TRELLIS_DAC_CHANNELS],
  input  logic                             trellisSync_i [`TRELLIS_DAC_CHANNELS],
  output logic [`TRELLIS_DATA_WIDTH-1:0]   rdData_o,
  output logic [`TRELLIS_DAC_WIDTH-1:0]    dacData_o [`TRELLIS_DAC_CHANNELS],
  output logic                             dacRst_o
);

  logic [2*`TRELLIS_DATA_WIDTH-1:0] miscData;
  logic                             miscWrite;
  logic                             miscReadStart;
  logic                             miscAccessStart;
  miscReg_t                         miscReg;
  logic                             softReset;
  logic                             chipReset;
  dacSource_t                       dacSource [`TRELLIS_DAC_CHANNELS];

  // Power-on reset or the stretched soft reset
  assign chipReset = clockCounterEn | softReset;
  assign dacRst_o  = chipReset;

  // **************************************************
  // Host bus and misc space
  // **************************************************

  hostBus i_hostBus (
    .ck933             (ck933),
    .clockCounterEn    (clockCounterEn),
    .nCs_i             (nCs_i),
    .nWe_i             (nWe_i),
    .nRd_i             (nRd_i),
    .addr_i            (addr_i),
    .wrData_i          (wrData_i),
    .miscData_i        (miscData),
    .softReset_i       (softReset),
    .rdData_o          (rdData_o),
    .miscWrite_o       (miscWrite),
    .miscReadStart_o   (miscReadStart),
    .miscAccessStart_o (miscAccessStart),
    .miscReg_o         (miscReg),
    .dacSource_o       (dacSource)
  );

  miscControl i_miscControl (
    .ck933             (ck933),
    .clockCounterEn    (clockCounterEn),
    .miscWrite_i       (miscWrite),
    .miscReadStart_i   (miscReadStart),
    .miscAccessStart_i (miscAccessStart),
    .miscReg_i         (miscReg),
    .miscData_o        (miscData),
    .softReset_o       (softReset)
  );

  // **************************************************
  // DAC channels
  // **************************************************

  for (genvar i = 0; i < `TRELLIS_DAC_CHANNELS; i++) begin : gDac
    dacChannel i_dacChannel (
      .ck933           (ck933),
      .chanReset_i     (chipReset),
      .dacSource_i     (dacSource[i]),
      .demodSample_i   (demodSample_i[i]),
      .demodSync_i     (demodSync_i[i]),
      .trellisSample_i (trellisSample_i[i]),
      .trellisSync_i   (trellisSync_i[i]),
      .dacData_o       (dacData_o[i])
    );
  end

endmodule

//--- source/dacChannel.sv
// One DAC output channel, two register stages from sample to pin
// Output is offset binary taken from the top bits of the sample

`include "trellisTop_cfg.svh"

module dacChannel
  import trellisTopPkg::*;
(
  input  logic                             ck933,
  input  logic                             chanReset_i,
  input  dacSource_t                       dacSource_i,
  input  logic [`TRELLIS_SAMPLE_WIDTH-1:0] demodSample_i,
  input  logic                             demodSync_i,
  input  logic [`TRELLIS_SAMPLE_WIDTH-1:0] trellisSample_i,
  input  logic                             trellisSync_i,
  output logic [`TRELLIS_DAC_WIDTH-1:0]    dacData_o
);

  logic                             useTrellis;
  logic [`TRELLIS_SAMPLE_WIDTH-1:0] selSample;
  logic                             selSync;

  // Trellis codes pick the trellis stream, anything else the demod
  always_comb begin
    case (dacSource_i)
      srcTrellisI, srcTrellisQ, srcTrellisPhErr, srcTrellisIndex: useTrellis = 1'b1;
      default: useTrellis = 1'b0;
    endcase
  end

  // **************************************************
  // Stage 1: source select
  // **************************************************

  always_ff @(posedge ck933 or posedge chanReset_i) begin
    if (chanReset_i) begin
      selSync <= 1'b0;
    end else begin
      selSync <= useTrellis ? trellisSync_i : demodSync_i;
    end
  end

  always_ff @(posedge ck933) begin
    selSample <= useTrellis ? trellisSample_i : demodSample_i;
  end

  // **************************************************
  // Stage 2: offset binary output
  // **************************************************

  // Inverting the sign bit turns two's complement into offset binary
  always_ff @(posedge ck933 or posedge chanReset_i) begin
    if (chanReset_i) begin
      dacData_o <= '0;
    end else if (selSync) begin
      dacData_o <= {~selSample[`TRELLIS_SAMPLE_WIDTH-1],
                    selSample[`TRELLIS_SAMPLE_WIDTH-2 -: `TRELLIS_DAC_WIDTH-1]};
    end
  end

endmodule

//--- source/miscControl.sv
// Misc register space: version, clock counter with capture, soft reset
// Only the power-on reset clears this block, so the stretcher runs to its end

`include "trellisTop_cfg.svh"

module miscControl
  import trellisTopPkg::*;
(
  input  logic                              ck933,
  input  logic                              clockCounterEn,
  input  logic                              miscWrite_i,
  input  logic                              miscReadStart_i,
  input  logic                              miscAccessStart_i,
  input  miscReg_t                          miscReg_i,
  output logic [2*`TRELLIS_DATA_WIDTH-1:0]  miscData_o,
  output logic                              softReset_o
);

  localparam int stretchWidth = $clog2(`TRELLIS_RESET_CYCLES);

  logic [2*`TRELLIS_DATA_WIDTH-1:0] clockCount;
  logic [2*`TRELLIS_DATA_WIDTH-1:0] clockHold;
  logic [stretchWidth-1:0]          stretchCount;
  logic                             clockRestart;
  logic                             resetRequest;

  assign clockRestart = miscWrite_i & (miscReg_i == miscClock);
  assign resetRequest = miscReadStart_i & (miscReg_i == miscReset);

  // **************************************************
  // Free-running clock counter
  // **************************************************

  // Zero at the write edge, then one count per edge
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      clockCount <= '0;
    end else if (clockRestart) begin
      clockCount <= '0;
    end else begin
      clockCount <= clockCount + 1'b1;
    end
  end

  // Capture on the first edge of any misc access
  // Holds the count of edges since the restart edge
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      clockHold <= '0;
    end else if (miscAccessStart_i) begin
      clockHold <= clockCount;
    end
  end

  // **************************************************
  // Soft reset stretcher
  // **************************************************

  // Flag rises the cycle after the read start
  // and stays high for RESET_CYCLES cycles
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      stretchCount <= '0;
      softReset_o  <= 1'b0;
    end else if (resetRequest) begin
      stretchCount <= stretchWidth'(`TRELLIS_RESET_CYCLES - 1);
      softReset_o  <= 1'b1;
    end else if (stretchCount != '0) begin
      stretchCount <= stretchCount - 1'b1;
    end else begin
      softReset_o  <= 1'b0;
    end
  end

  // **************************************************
  // Read data
  // **************************************************

  always_comb begin
    case (miscReg_i)
      miscVersion: begin
        miscData_o = {`TRELLIS_VERSION, {`TRELLIS_DATA_WIDTH{1'b0}}};
      end
      miscClock: begin
        miscData_o = clockHold;
      end
      // Reset register and unused slots read zero
      default: begin
        miscData_o = '0;
      end
    endcase
  end

endmodule

//--- source/hostBus.sv
// Host bus sampled on ck933, the host holds signals across one rising edge
// Read data is combinational while nCs and nRd are low, zero otherwise
// Unmapped addresses read as zero

`include "trellisTop_cfg.svh"

module hostBus
  import trellisTopPkg::*;
(
  input  logic                              ck933,
  input  logic                              clockCounterEn,
  input  logic                              nCs_i,
  input  logic                              nWe_i,
  input  logic                              nRd_i,
  input  logic [`TRELLIS_ADDR_WIDTH-1:0]    addr_i,
  input  logic [`TRELLIS_DATA_WIDTH-1:0]    wrData_i,
  input  logic [2*`TRELLIS_DATA_WIDTH-1:0]  miscData_i,
  input  logic                              softReset_i,
  output logic [`TRELLIS_DATA_WIDTH-1:0]    rdData_o,
  output logic                              miscWrite_o,
  output logic                              miscReadStart_o,
  output logic                              miscAccessStart_o,
  output miscReg_t                          miscReg_o,
  output dacSource_t                        dacSource_o [`TRELLIS_DAC_CHANNELS]
);

  addrSpace_t space;
  logic       csActive;
  logic       csPrev;
  logic       accessStart;
  logic       wrStrobe;
  logic       rdActive;
  logic       inMisc;
  logic       inDacSel;
  logic [1:0] chanSel;
  logic       chanValid;
  logic       sourceReset;

  // **************************************************
  // Address decode
  // **************************************************

  always_comb begin
    case (addrSpace_t'(addr_i[11:8]))
      spaceMisc:   space = spaceMisc;
      spaceDacSel: space = spaceDacSel;
      default:     space = spaceNone;
    endcase
  end

  assign inMisc    = (space == spaceMisc);
  assign inDacSel  = (space == spaceDacSel);
  assign miscReg_o = miscReg_t'(addr_i[7:2]);

  // Channel index for the DAC select registers
  assign chanSel   = addr_i[3:2];
  assign chanValid = (chanSel < `TRELLIS_DAC_CHANNELS);

  // **************************************************
  // Access strobes
  // **************************************************

  assign csActive = ~nCs_i;
  assign wrStrobe = csActive & ~nWe_i;
  assign rdActive = csActive & ~nRd_i;

  // Previous chip select marks the first edge of an access
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      csPrev <= 1'b0;
    end else begin
      csPrev <= csActive;
    end
  end

  assign accessStart       = csActive & ~csPrev;
  assign miscWrite_o       = wrStrobe & inMisc;
  assign miscAccessStart_o = accessStart & inMisc;
  assign miscReadStart_o   = miscAccessStart_o & ~nRd_i;

  // **************************************************
  // DAC source registers
  // **************************************************

  // Cleared by power-on reset and by the soft reset pulse
  assign sourceReset = clockCounterEn | softReset_i;

  always_ff @(posedge ck933 or posedge sourceReset) begin
    if (sourceReset) begin
      for (int i = 0; i < `TRELLIS_DAC_CHANNELS; i++) begin
        dacSource_o[i] <= srcDemod;
      end
    end else if (wrStrobe && inDacSel && chanValid) begin
      // Unnamed codes are kept as written
      dacSource_o[chanSel] <= dacSource_t'(wrData_i[3:0]);
    end
  end

  // **************************************************
  // Read data mux
  // **************************************************

  always_comb begin
    rdData_o = '0;
    if (rdActive) begin
      case (space)
        spaceMisc: begin
          // addr[1] picks the upper half
          if (addr_i[1]) begin
            rdData_o = miscData_i[2*`TRELLIS_DATA_WIDTH-1:`TRELLIS_DATA_WIDTH];
          end else begin
            rdData_o = miscData_i[`TRELLIS_DATA_WIDTH-1:0];
          end
        end
        spaceDacSel: begin
          if (chanValid) begin
            rdData_o = {{(`TRELLIS_DATA_WIDTH-4){1'b0}}, dacSource_o[chanSel]};
          end
        end
        default: rdData_o = '0;
      endcase
    end
  end

endmodule

//--- source/trellisTopPkg.sv
// Enum types shared by the host bus, misc block and DAC channels
// Encodings follow the legacy address map

package trellisTopPkg;

  // **************************************************
  // Address spaces, decoded from addr[11:8]
  // **************************************************

  typedef enum logic [3:0] {
    spaceMisc   = 4'h0,
    spaceDacSel = 4'h1,
    // Any other code lands here after decode
    spaceNone   = 4'hf
  } addrSpace_t;

  // **************************************************
  // Misc registers, decoded from addr[7:2]
  // **************************************************

  typedef enum logic [5:0] {
    // Read triggers the soft reset pulse
    miscReset   = 6'd0,
    miscVersion = 6'd1,
    // Write restarts the counter, read returns the capture
    miscClock   = 6'd2
  } miscReg_t;

  // **************************************************
  // DAC source codes
  // **************************************************

  // Codes 5 to 15 are not named and select the demod stream
  typedef enum logic [3:0] {
    srcDemod        = 4'd0,
    srcTrellisI     = 4'd1,
    srcTrellisQ     = 4'd2,
    srcTrellisPhErr = 4'd3,
    srcTrellisIndex = 4'd4
  } dacSource_t;

endpackage

//--- source/trellisTop_cfg.svh
// Fixed build constants for the trellis top level
// Channel count and widths are not parameters of any module

`ifndef TRELLIS_TOP_CFG_SVH
`define TRELLIS_TOP_CFG_SVH

// **************************************************
// Host bus
// **************************************************

// Data bus width, a 32-bit register is read as two halves
`define TRELLIS_DATA_WIDTH 16

// Byte address, bit 0 is not decoded
`define TRELLIS_ADDR_WIDTH 12

// **************************************************
// Sample streams and DAC outputs
// **************************************************

`define TRELLIS_SAMPLE_WIDTH 18
`define TRELLIS_DAC_WIDTH 14
`define TRELLIS_DAC_CHANNELS 3

// **************************************************
// Misc space
// **************************************************

// Shown in the upper half of the version register
`define TRELLIS_VERSION 16'h009b

// Soft reset pulse length in ck933 cycles
`define TRELLIS_RESET_CYCLES 6

`endif
